// File: filelist.f
+incdir+hw
hw/rv_alu_pkg.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/write_back.sv
hw/rv_alu_core.sv
tb/rv_alu_core_sva.sv
tb/tb_rv_alu_core.sv

// File: run.sh
#!/bin/sh
# build with verilator, run, then scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f filelist.f --top-module tb_rv_alu_core \
  -o tb_rv_alu_core || exit 1
./obj_dir/tb_rv_alu_core > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "Some tests failed" sim.log && exit 1
grep -q "All tests passed" sim.log || exit 1
exit 0

// File: tb/tb_rv_alu_core.sv
`timescale 1ns/1ps
`include "rv_alu_defs.svh"

module tb_rv_alu_core;

  // the tests need roughly 180 cycles, this leaves about twice that
  localparam int TIMEOUT_CYCLES = 400;

  logic                clk;
  logic                rst_n_i;
  logic                inst_valid_i;
  logic [`RV_XLEN-1:0] inst_i;
  logic                ret_valid_o;
  rv_alu_pkg::ret_t    ret_o;

  logic [`RV_XLEN-1:0] shadow [0:`RV_NREGS-1];
  rv_alu_pkg::ret_t    exp_q [$];
  int                  due_q [$];
  rv_alu_pkg::ret_t    exp_rep;
  int                  exp_due;
  int                  cycle;
  int                  check_count;
  int                  error_count;
  integer              seed;

  rv_alu_core u_rv_alu_core (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .ret_valid_o  (ret_valid_o),
    .ret_o        (ret_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // ========================================
  // encoders and reference model
  // ========================================

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, `RV_OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, `RV_OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, `RV_OPC_LUI};
  endfunction

  // k: add sub sll slt sltu xor srl sra or and; sub becomes addi in immediate form
  function automatic logic [31:0] op_inst(input int k, input logic use_imm,
                                          input logic [4:0] rs1, input logic [4:0] rs2,
                                          input logic [11:0] imm, input logic [4:0] rd);
    logic [2:0] f3;
    logic [6:0] f7;
    f7 = (k == 1 || k == 7) ? `RV_F7_ALT : 7'h00;
    f3 = (k < 2) ? 3'b000 : (k < 7) ? 3'(k - 1) : 3'(k - 2);
    if (!use_imm) begin
      return enc_r(f7, rs2, rs1, f3, rd);
    end
    return (f3 == 3'b001 || f3 == 3'b101) ? enc_i({f7, imm[4:0]}, rs1, f3, rd)
                                          : enc_i(imm, rs1, f3, rd);
  endfunction

  // rv32i semantics on the shadow registers
  function automatic rv_alu_pkg::ret_t ref_exec(input logic [31:0] inst);
    logic [6:0]       opc;
    logic [2:0]       f3;
    logic [6:0]       f7;
    logic             alt;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      res;
    rv_alu_pkg::ret_t rep;
    opc = inst[6:0];
    f3  = inst[14:12];
    f7  = inst[31:25];
    a   = shadow[inst[19:15]];
    b   = (opc == `RV_OPC_OP) ? shadow[inst[24:20]] : {{20{inst[31]}}, inst[31:20]};
    alt = (f7 == `RV_F7_ALT) && (opc == `RV_OPC_OP || f3 == 3'b101);
    rep.rd      = inst[11:7];
    rep.illegal = 1'b0;
    case (f3)
      3'b000:  res = alt ? a - b : a + b;
      3'b001:  res = a << b[4:0];
      3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  res = (a < b) ? 32'd1 : 32'd0;
      3'b100:  res = a ^ b;
      3'b101:  res = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  res = a | b;
      default: res = a & b;
    endcase
    if (opc == `RV_OPC_LUI) begin
      res = {inst[31:12], 12'h000};
    end else if (opc == `RV_OPC_OP) begin
      rep.illegal = (f7 != 7'h00) && !(alt && (f3 == 3'b000 || f3 == 3'b101));
    end else if (opc == `RV_OPC_OP_IMM) begin
      rep.illegal = (f3 == 3'b001 && f7 != 7'h00) || (f3 == 3'b101 && f7 != 7'h00 && !alt);
    end else begin
      rep.illegal = 1'b1;
    end
    rep.data = rep.illegal ? 32'd0 : res;
    return rep;
  endfunction

  // ========================================
  // drivers and checker
  // ========================================

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  // one strobe, report due two edges later
  task automatic issue(input logic [31:0] inst);
    rv_alu_pkg::ret_t rep;
    rep = ref_exec(inst);
    if (!rep.illegal && rep.rd != 5'd0) begin
      shadow[rep.rd] = rep.data;
    end
    exp_q.push_back(rep);
    due_q.push_back(cycle + 2);
    inst_valid_i = 1'b1;
    inst_i       = inst;
    idle(1);
    inst_valid_i = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      idle(1);
    end
  endtask

  // lui then a dependent addi
  task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = value + 32'h800;
    issue(enc_u(upper[31:12], rd));
    issue(enc_i(value[11:0], rd, 3'b000, rd));
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      $display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp);
      error_count++;
    end
  endtask

  always @(negedge clk) begin
    if (ret_valid_o && exp_q.size() == 0) begin
      $display("retire report with no instruction outstanding at cycle %0d", cycle);
      error_count++;
    end else if (ret_valid_o) begin
      exp_rep = exp_q.pop_front();
      exp_due = due_q.pop_front();
      if (exp_due != cycle) begin
        $display("report for rd %0d at cycle %0d, expected at %0d", exp_rep.rd, cycle, exp_due);
        error_count++;
      end
      check_word("ret_o.rd", {27'd0, ret_o.rd}, {27'd0, exp_rep.rd});
      check_word("ret_o.data", ret_o.data, exp_rep.data);
      check_word("ret_o.illegal", {31'd0, ret_o.illegal}, {31'd0, exp_rep.illegal});
    end else if (exp_q.size() != 0 && due_q[0] <= cycle) begin
      $display("no retire report at cycle %0d for rd %0d", cycle, exp_q[0].rd);
      error_count++;
      exp_rep = exp_q.pop_front();
      exp_due = due_q.pop_front();
    end
  end

  // ========================================
  // directed tests
  // ========================================

  task automatic test_reset_strobe();
    idle(4);
    issue(enc_i(12'h005, 5'd0, 3'b000, 5'd1));
    idle(3);
    issue(enc_i(12'hfff, 5'd1, 3'b000, 5'd2));
    idle(1);
    issue(enc_i(12'h010, 5'd2, 3'b110, 5'd3));
    drain();
  endtask

  task automatic test_op_imm();
    int          k;
    logic [31:0] rnd;
    for (k = 0; k < 20; k++) begin
      rnd = $random(seed);
      load_reg(5'd5, rnd);
      rnd = $random(seed);
      issue(op_inst(k % 10, 1'b1, 5'd5, 5'd0, rnd[11:0], 5'(6 + k % 10)));
    end
    drain();
  endtask

  task automatic test_op();
    int          k;
    logic [31:0] rnd;
    rnd = $random(seed);
    load_reg(5'd10, rnd | 32'h8000_0000);
    rnd = $random(seed);
    load_reg(5'd11, rnd & 32'h7fff_ffff);
    load_reg(5'd12, 32'h0000_0013);
    for (k = 0; k < 10; k++) begin
      issue(op_inst(k, 1'b0, 5'd10, 5'd11, 12'd0, 5'(13 + k)));
    end
    // negative operand on the other side, shift amount from a register
    issue(op_inst(4, 1'b0, 5'd11, 5'd10, 12'd0, 5'd24));
    issue(op_inst(3, 1'b0, 5'd11, 5'd10, 12'd0, 5'd25));
    issue(op_inst(7, 1'b0, 5'd10, 5'd12, 12'd0, 5'd26));
    drain();
  endtask

  // gap 0 hits exe forwarding, gap 1 hits write-through
  task automatic test_forwarding();
    int          k;
    int          gap;
    logic [31:0] rnd;
    for (k = 0; k < 8; k++) begin
      gap = (k >= 4) ? 1 : 0;
      rnd = $random(seed);
      issue(enc_i(rnd[11:0], 5'd0, 3'b000, 5'd1));
      idle(gap);
      issue(op_inst(0, 1'b0, 5'd1, 5'd1, 12'd0, 5'd2));
      idle(gap);
      issue(op_inst(k, 1'b0, 5'd2, 5'd1, 12'd0, 5'd3));
      idle(gap);
      issue(op_inst(9 - k, 1'b1, 5'd3, 5'd0, rnd[23:12], 5'd4));
    end
    drain();
  endtask

  task automatic test_x0_lui();
    issue(enc_i(12'h123, 5'd0, 3'b000, 5'd0));
    issue(op_inst(0, 1'b0, 5'd0, 5'd0, 12'd0, 5'd7));
    issue(enc_i(12'h001, 5'd0, 3'b000, 5'd8));
    issue(enc_u(20'habcde, 5'd9));
    issue(op_inst(5, 1'b1, 5'd9, 5'd0, 12'h000, 5'd10));
    drain();
  endtask

  task automatic test_illegal();
    load_reg(5'd20, 32'h1234_5678);
    // branch opcode is outside the kept classes
    issue({20'h12345, 5'd20, 7'b1100011});
    issue(op_inst(0, 1'b0, 5'd20, 5'd0, 12'd0, 5'd21));
    issue(enc_r(7'h01, 5'd20, 5'd20, 3'b000, 5'd20));
    issue(enc_r(`RV_F7_ALT, 5'd20, 5'd20, 3'b001, 5'd20));
    issue(enc_i({`RV_F7_ALT, 5'd3}, 5'd20, 3'b001, 5'd20));
    issue(enc_i({7'h01, 5'd3}, 5'd20, 3'b101, 5'd20));
    issue(op_inst(0, 1'b0, 5'd20, 5'd0, 12'd0, 5'd21));
    idle(1);
    issue(op_inst(0, 1'b1, 5'd20, 5'd0, 12'd0, 5'd22));
    drain();
  endtask

  initial begin
    while (cycle < TIMEOUT_CYCLES) begin
      @(posedge clk);
    end
    $display("timeout at cycle %0d, %0d reports outstanding", cycle, exp_q.size());
    $display("Some tests failed");
    $finish;
  end

  initial begin
    seed         = 3196;
    rst_n_i      = 1'b0;
    inst_valid_i = 1'b0;
    inst_i       = '0;
    shadow       = '{default: '0};
    repeat (3) @(posedge clk);
    #2;
    rst_n_i = 1'b1;
    test_reset_strobe();
    test_op_imm();
    test_op();
    test_forwarding();
    test_x0_lui();
    test_illegal();
    idle(3);
    $display("%0d checks, %0d errors", check_count, error_count);
    if (error_count == 0 && check_count > 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: tb/rv_alu_core_sva.sv
`timescale 1ns/1ps

module rv_alu_core_sva (
  input logic             clk,
  input logic             rst_n_i,
  input logic             inst_valid_i,
  input logic             ret_valid_i,
  input rv_alu_pkg::ret_t ret_i
);

  // pipeline registers are cleared while reset is low
  assert property (@(posedge clk) !rst_n_i |-> !ret_valid_i)
    else $error("ret_valid_o high during reset");

  // strobe to report is always two edges
  assert property (@(posedge clk) disable iff (!rst_n_i)
                   ret_valid_i == $past(inst_valid_i, 2))
    else $error("ret_valid_o does not follow inst_valid_i by two edges");

  // illegal reports carry zero data
  assert property (@(posedge clk) disable iff (!rst_n_i)
                   (ret_valid_i && ret_i.illegal) |-> (ret_i.data == '0))
    else $error("illegal report with nonzero ret_o.data");

endmodule

bind rv_alu_core rv_alu_core_sva u_rv_alu_core_sva (
  .clk          (clk),
  .rst_n_i      (rst_n_i),
  .inst_valid_i (inst_valid_i),
  .ret_valid_i  (ret_valid_o),
  .ret_i        (ret_o)
);

// File: hw/rv_alu_core.sv
`timescale 1ns/1ps
`include "rv_alu_defs.svh"

module rv_alu_core (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic                inst_valid_i,
  input  logic [`RV_XLEN-1:0] inst_i,
  output logic                ret_valid_o,
  output rv_alu_pkg::ret_t    ret_o
);

  logic [`RV_REG_AW-1:0] rs1;
  logic [`RV_REG_AW-1:0] rs2;
  logic [`RV_XLEN-1:0]   rdata1;
  logic [`RV_XLEN-1:0]   rdata2;
  rv_alu_pkg::dec_pkt_t  dec_q;
  rv_alu_pkg::exe_pkt_t  exe_q;

  // decode, reads the register file
  decode_stage u_decode_stage (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .rs1_o        (rs1),
    .rs2_o        (rs2),
    .rdata1_i     (rdata1),
    .rdata2_i     (rdata2),
    .dec_o        (dec_q)
  );

  // forwarding and alu
  execute_stage u_execute_stage (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .dec_i   (dec_q),
    .exe_o   (exe_q)
  );

  // register file write and retire port
  write_back u_write_back (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .exe_i       (exe_q),
    .rs1_i       (rs1),
    .rs2_i       (rs2),
    .rdata1_o    (rdata1),
    .rdata2_o    (rdata2),
    .ret_valid_o (ret_valid_o),
    .ret_o       (ret_o)
  );

endmodule

// File: hw/write_back.sv
`timescale 1ns/1ps
`include "rv_alu_defs.svh"

module write_back (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  rv_alu_pkg::exe_pkt_t  exe_i,
  input  logic [`RV_REG_AW-1:0] rs1_i,
  input  logic [`RV_REG_AW-1:0] rs2_i,
  output logic [`RV_XLEN-1:0]   rdata1_o,
  output logic [`RV_XLEN-1:0]   rdata2_o,
  output logic                  ret_valid_o,
  output rv_alu_pkg::ret_t      ret_o
);

  // x0 has no storage
  logic [`RV_XLEN-1:0] regs [1:`RV_NREGS-1];
  logic                we;

  assign we = exe_i.valid && !exe_i.illegal && (exe_i.rd != '0);

  // read port with write-through of the pending write
  function automatic logic [`RV_XLEN-1:0] read_port(input logic [`RV_REG_AW-1:0] addr);
    if (addr == '0) begin
      return '0;
    end
    if (we && addr == exe_i.rd) begin
      return exe_i.result;
    end
    return regs[addr];
  endfunction

  // ========================================
  // register file
  // ========================================

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[exe_i.rd] <= exe_i.result;
    end
  end

  always_comb begin
    rdata1_o = read_port(rs1_i);
    rdata2_o = read_port(rs2_i);
  end

  // ========================================
  // retire report
  // ========================================

  // every valid packet retires, legal or not
  assign ret_valid_o   = exe_i.valid;
  assign ret_o.rd      = exe_i.rd;
  assign ret_o.data    = exe_i.result;
  assign ret_o.illegal = exe_i.illegal;

endmodule

// File: hw/execute_stage.sv
`timescale 1ns/1ps
`include "rv_alu_defs.svh"

module execute_stage (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  rv_alu_pkg::dec_pkt_t dec_i,
  output rv_alu_pkg::exe_pkt_t exe_o
);

  logic [`RV_XLEN-1:0]  op_a;
  logic [`RV_XLEN-1:0]  rs2_val;
  logic [`RV_XLEN-1:0]  op_b;
  logic [`RV_XLEN-1:0]  alu_res;
  logic [4:0]           shamt;
  rv_alu_pkg::exe_pkt_t exe_d;
  rv_alu_pkg::exe_pkt_t exe_q;

  // take the previous result when it targets this source
  function automatic logic [`RV_XLEN-1:0] fwd_sel(
    input logic [`RV_REG_AW-1:0] addr,
    input logic [`RV_XLEN-1:0]   rf_data,
    input rv_alu_pkg::exe_pkt_t  prev
  );
    if (prev.valid && !prev.illegal && addr != '0 && addr == prev.rd) begin
      return prev.result;
    end
    return rf_data;
  endfunction

  // ========================================
  // operand selection
  // ========================================

  assign op_a    = fwd_sel(dec_i.rs1, dec_i.rdata1, exe_q);
  assign rs2_val = fwd_sel(dec_i.rs2, dec_i.rdata2, exe_q);
  assign op_b    = dec_i.use_imm ? dec_i.imm : rs2_val;
  assign shamt   = op_b[4:0];

  // ========================================
  // alu
  // ========================================

  always_comb begin
    case (dec_i.alu_op)
      rv_alu_pkg::ALU_ADD:    alu_res = op_a + op_b;
      rv_alu_pkg::ALU_SUB:    alu_res = op_a - op_b;
      rv_alu_pkg::ALU_SLL:    alu_res = op_a << shamt;
      rv_alu_pkg::ALU_SLT:    alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      rv_alu_pkg::ALU_SLTU:   alu_res = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
      rv_alu_pkg::ALU_XOR:    alu_res = op_a ^ op_b;
      rv_alu_pkg::ALU_SRL:    alu_res = op_a >> shamt;
      rv_alu_pkg::ALU_SRA:    alu_res = $unsigned($signed(op_a) >>> shamt);
      rv_alu_pkg::ALU_OR:     alu_res = op_a | op_b;
      rv_alu_pkg::ALU_AND:    alu_res = op_a & op_b;
      rv_alu_pkg::ALU_PASS_B: alu_res = op_b;
      default:                alu_res = '0;
    endcase
  end

  always_comb begin
    exe_d.valid   = dec_i.valid;
    exe_d.illegal = dec_i.illegal;
    exe_d.rd      = dec_i.rd;
    // illegal ops retire with zero data
    exe_d.result  = dec_i.illegal ? '0 : alu_res;
  end

  // execute pipeline register
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exe_q <= '0;
    end else begin
      exe_q <= exe_d;
    end
  end

  assign exe_o = exe_q;

endmodule

// File: hw/decode_stage.sv
`timescale 1ns/1ps
`include "rv_alu_defs.svh"

module decode_stage (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  inst_valid_i,
  input  logic [`RV_XLEN-1:0]   inst_i,
  output logic [`RV_REG_AW-1:0] rs1_o,
  output logic [`RV_REG_AW-1:0] rs2_o,
  input  logic [`RV_XLEN-1:0]   rdata1_i,
  input  logic [`RV_XLEN-1:0]   rdata2_i,
  output rv_alu_pkg::dec_pkt_t  dec_o
);

  logic [6:0]             opcode;
  logic [2:0]             funct3;
  logic [6:0]             funct7;
  logic [`RV_REG_AW-1:0]  rd;
  logic                   alt;
  logic                   illegal;
  logic [`RV_XLEN-1:0]    imm;
  rv_alu_pkg::opc_e       opc;
  rv_alu_pkg::alu_op_e    alu_op;
  rv_alu_pkg::dec_pkt_t   dec_d;
  rv_alu_pkg::dec_pkt_t   dec_q;

  // ========================================
  // field extraction
  // ========================================

  assign opcode = inst_i[6:0];
  assign rd     = inst_i[11:7];
  assign funct3 = inst_i[14:12];
  assign rs1_o  = inst_i[19:15];
  assign rs2_o  = inst_i[24:20];
  assign funct7 = inst_i[31:25];

  always_comb begin
    case (opcode)
      `RV_OPC_OP:     opc = rv_alu_pkg::OPC_OP;
      `RV_OPC_OP_IMM: opc = rv_alu_pkg::OPC_OP_IMM;
      `RV_OPC_LUI:    opc = rv_alu_pkg::OPC_LUI;
      default:        opc = rv_alu_pkg::OPC_BAD;
    endcase
  end

  // bit 30 is immediate data for addi, so only OP and right shifts look at it
  assign alt = funct7[5] && ((opc == rv_alu_pkg::OPC_OP) || (funct3 == 3'b101));

  always_comb begin
    case (funct3)
      3'b000:  alu_op = alt ? rv_alu_pkg::ALU_SUB : rv_alu_pkg::ALU_ADD;
      3'b001:  alu_op = rv_alu_pkg::ALU_SLL;
      3'b010:  alu_op = rv_alu_pkg::ALU_SLT;
      3'b011:  alu_op = rv_alu_pkg::ALU_SLTU;
      3'b100:  alu_op = rv_alu_pkg::ALU_XOR;
      3'b101:  alu_op = alt ? rv_alu_pkg::ALU_SRA : rv_alu_pkg::ALU_SRL;
      3'b110:  alu_op = rv_alu_pkg::ALU_OR;
      default: alu_op = rv_alu_pkg::ALU_AND;
    endcase
    // lui just moves the immediate through
    if (opc == rv_alu_pkg::OPC_LUI) begin
      alu_op = rv_alu_pkg::ALU_PASS_B;
    end
  end

  // ========================================
  // legality and immediate
  // ========================================

  always_comb begin
    illegal = 1'b0;
    case (opc)
      rv_alu_pkg::OPC_OP: begin
        if (funct7 != 7'd0 && funct7 != `RV_F7_ALT) begin
          illegal = 1'b1;
        end
        // alt form exists for sub and sra only
        if (funct7 == `RV_F7_ALT && funct3 != 3'b000 && funct3 != 3'b101) begin
          illegal = 1'b1;
        end
      end
      rv_alu_pkg::OPC_OP_IMM: begin
        // shift encodings keep funct7 in imm[11:5]
        if (funct3 == 3'b001 && funct7 != 7'd0) begin
          illegal = 1'b1;
        end
        if (funct3 == 3'b101 && funct7 != 7'd0 && funct7 != `RV_F7_ALT) begin
          illegal = 1'b1;
        end
      end
      rv_alu_pkg::OPC_LUI: illegal = 1'b0;
      default:             illegal = 1'b1;
    endcase
  end

  // u-type for lui, sign extended i-type otherwise
  assign imm = (opc == rv_alu_pkg::OPC_LUI) ? {inst_i[31:12], 12'd0}
                                            : {{20{inst_i[31]}}, inst_i[31:20]};

  always_comb begin
    dec_d.valid   = inst_valid_i;
    dec_d.illegal = illegal;
    dec_d.use_imm = (opc != rv_alu_pkg::OPC_OP);
    dec_d.alu_op  = alu_op;
    dec_d.rs1     = rs1_o;
    dec_d.rs2     = rs2_o;
    dec_d.rd      = rd;
    dec_d.rdata1  = rdata1_i;
    dec_d.rdata2  = rdata2_i;
    dec_d.imm     = imm;
  end

  // decode pipeline register
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dec_q <= '0;
    end else begin
      dec_q <= dec_d;
    end
  end

  assign dec_o = dec_q;

endmodule

// File: hw/rv_alu_pkg.sv
`include "rv_alu_defs.svh"

package rv_alu_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [`RV_REG_AW-1:0] reg_addr_t;

  // instruction class
  typedef enum logic [1:0] {
    OPC_OP,
    OPC_OP_IMM,
    OPC_LUI,
    OPC_BAD
  } opc_e;

  // alu operation
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  // decode to execute
  typedef struct packed {
    logic      valid;
    logic      illegal;
    logic      use_imm;
    alu_op_e   alu_op;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     rdata1;
    word_t     rdata2;
    word_t     imm;
  } dec_pkt_t;

  // execute to result, also the forwarding source
  typedef struct packed {
    logic      valid;
    logic      illegal;
    reg_addr_t rd;
    word_t     result;
  } exe_pkt_t;

  // retire report at the top level
  typedef struct packed {
    reg_addr_t rd;
    word_t     data;
    logic      illegal;
  } ret_t;

endpackage

// File: hw/rv_alu_defs.svh
`ifndef RV_ALU_DEFS_SVH
`define RV_ALU_DEFS_SVH

// ========================================
// datapath widths
// ========================================

// data word
`define RV_XLEN 32

// register address and count
`define RV_REG_AW 5
`define RV_NREGS 32

// ========================================
// instruction encodings
// ========================================

// major opcodes of the kept classes
`define RV_OPC_OP 7'b0110011
`define RV_OPC_OP_IMM 7'b0010011
`define RV_OPC_LUI 7'b0110111

// funct7 for sub and sra
`define RV_F7_ALT 7'b0100000

`endif
